//--- Bender.yml
package:
  name: mult_unit

sources:
  - mult_pkg.sv
  - mult_stage.sv
  - mult_pipe.sv
  - mult_operand_regs.sv
  - mult_result_fifo.sv
  - mult_bus_ctrl.sv
  - mult_unit_top.sv
  - target: test
    files:
      - tb_mult_checker.sv
      - tb_mult_unit.sv

//--- mult_bus_ctrl.sv
`timescale 1ns/1ps

module mult_bus_ctrl #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic                clock,
	input  logic                reset,
	input  logic                cyc,
	input  logic                stb,
	input  logic                we,
	input  mult_pkg::adr_t      adr,
	input  mult_pkg::word_t     dat_w,
	output logic                ack,
	output mult_pkg::word_t     dat_r,
	input  mult_pkg::word_t     opa,
	input  mult_pkg::word_t     opb,
	input  mult_pkg::word_t     fifo_head,
	input  mult_pkg::count_t    fifo_count,
	input  logic                done,
	output logic                opa_load,
	output logic                opb_load,
	output logic                start,
	output mult_pkg::mul_func_t func,
	output logic                pop
);

	typedef enum logic {
		st_idle,    // waiting for / decoding a request
		st_respond  // ack cycle
	} state_t;

	state_t           state, state_next;
	mult_pkg::count_t inflight;   // launched, not yet done
	logic [8:0]       occupancy;  // inflight + fifo, one extra bit
	logic             credit_ok;
	logic             req;
	logic             is_cmd_wr;
	mult_pkg::word_t  status;

	assign req       = cyc && stb;
	assign is_cmd_wr = we && (adr == mult_pkg::reg_cmd);

	// room for one more result once everything in flight lands
	assign occupancy = {1'b0, inflight} + {1'b0, fifo_count};
	assign credit_ok = (occupancy < 9'(FIFO_DEPTH));

	////////////////////
	// handshake FSM
	////////////////////

	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (req && (!is_cmd_wr || credit_ok)) begin
					state_next = st_respond; // no credit, hold in wait states
				end
			end
			default: state_next = st_idle; // master drops stb after ack
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			state <= state_next;
		end
	end

	assign ack = (state == st_respond); // straight from the state flop

	// strobes fire on the ack cycle, master still holds adr/we/dat_w
	assign opa_load = ack && we && (adr == mult_pkg::reg_opa);
	assign opb_load = ack && we && (adr == mult_pkg::reg_opb);
	assign start    = ack && is_cmd_wr;
	assign pop      = ack && !we && (adr == mult_pkg::reg_result);
	assign func     = mult_pkg::mul_func_t'(dat_w[1:0]);

	////////////////////
	// in-flight counter
	////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			inflight <= '0;
		end else begin
			case ({start, done})
				2'b10:   inflight <= inflight + 1'b1;
				2'b01:   inflight <= inflight - 1'b1;
				default: inflight <= inflight; // both or neither
			endcase
		end
	end

	////////////////////
	// read mux
	////////////////////

	always_comb begin
		status = '0;
		status[mult_pkg::status_fifo_lsb +: 8]   = fifo_count;
		status[mult_pkg::status_flight_lsb +: 8] = inflight;
	end

	always_comb begin
		case (adr)
			mult_pkg::reg_opa: dat_r = opa;
			mult_pkg::reg_opb: dat_r = opb;
			mult_pkg::reg_cmd: dat_r = status;
			default:           dat_r = fifo_head; // zero when empty
		endcase
	end

endmodule

//--- mult_operand_regs.sv
`timescale 1ns/1ps

module mult_operand_regs (
	input  logic            clock,
	input  logic            reset,
	input  logic            opa_load,
	input  logic            opb_load,
	input  mult_pkg::word_t wdata,
	output mult_pkg::word_t opa,
	output mult_pkg::word_t opb
);

	////////////////////
	// operand a
	////////////////////

	// kept across launches so one value serves several commands
	always_ff @(posedge clock) begin
		if (reset) begin
			opa <= '0;
		end else if (opa_load) begin
			opa <= wdata; // full word write
		end
	end

	////////////////////
	// operand b
	////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			opb <= '0;
		end else if (opb_load) begin
			opb <= wdata;
		end
	end

	// load strobes come from the ack cycle of the bus write
	// so the new value shows up one cycle after ack
	// a command written next acks at least two cycles later and sees it

endmodule

//--- mult_pipe.sv
`timescale 1ns/1ps

module mult_pipe #(
	parameter int NUM_STAGES = 4
) (
	input  logic                clock,
	input  logic                reset,
	input  logic                start,
	input  mult_pkg::mul_func_t func,
	input  mult_pkg::word_t     opa,
	input  mult_pkg::word_t     opb,
	output logic                done,
	output mult_pkg::word_t     result
);

	localparam int xlen = mult_pkg::xlen;

	logic             a_signed, b_signed;
	mult_pkg::dword_t mcand_ext, mplier_ext; // opa is mcand, opb is mplier

	// chain taps, index 0 feeds stage 0, index NUM_STAGES is the tail
	logic             done_chain    [NUM_STAGES+1];
	logic             upper_chain   [NUM_STAGES+1];
	mult_pkg::dword_t mplier_chain  [NUM_STAGES+1];
	mult_pkg::dword_t mcand_chain   [NUM_STAGES+1];
	mult_pkg::dword_t product_chain [NUM_STAGES+1];

	////////////////////
	// operand signs
	////////////////////

	always_comb begin
		case (func)
			mult_pkg::mul_lo, mult_pkg::mul_hi_ss: begin
				a_signed = 1'b1;
				b_signed = 1'b1;
			end
			mult_pkg::mul_hi_su: begin
				a_signed = 1'b1; // only rs1 signed
				b_signed = 1'b0;
			end
			default: begin // mulhu
				a_signed = 1'b0;
				b_signed = 1'b0;
			end
		endcase
	end

	assign mcand_ext  = a_signed ? {{xlen{opa[xlen-1]}}, opa} : {{xlen{1'b0}}, opa};
	assign mplier_ext = b_signed ? {{xlen{opb[xlen-1]}}, opb} : {{xlen{1'b0}}, opb};

	// head of chain
	assign done_chain[0]    = start;
	assign upper_chain[0]   = (func != mult_pkg::mul_lo);
	assign mplier_chain[0]  = mplier_ext;
	assign mcand_chain[0]   = mcand_ext;
	assign product_chain[0] = '0;

	////////////////////
	// stage chain
	////////////////////

	for (genvar i = 0; i < NUM_STAGES; i++) begin : g_stage
		mult_stage #(.NUM_STAGES(NUM_STAGES)) i_stage (
			.clock       (clock),
			.reset       (reset),
			.start       (done_chain[i]),
			.mplier_in   (mplier_chain[i]),
			.mcand_in    (mcand_chain[i]),
			.product_in  (product_chain[i]),
			.upper_in    (upper_chain[i]),
			.done        (done_chain[i+1]),
			.mplier_out  (mplier_chain[i+1]),
			.mcand_out   (mcand_chain[i+1]),
			.product_out (product_chain[i+1]),
			.upper_out   (upper_chain[i+1])
		);
	end

	// half select at the tail, flag came down with the data
	assign done   = done_chain[NUM_STAGES];
	assign result = upper_chain[NUM_STAGES] ? product_chain[NUM_STAGES][2*xlen-1:xlen]
	                                        : product_chain[NUM_STAGES][xlen-1:0];

endmodule

//--- mult_pkg.sv
package mult_pkg;

	////////////////////
	// widths and word types
	////////////////////

	localparam int xlen = 32; // operand width

	typedef logic [xlen-1:0]   word_t;  // operands, results, bus data
	typedef logic [2*xlen-1:0] dword_t; // full product, stage values
	typedef logic [7:0]        count_t; // fifo and in-flight counts
	typedef logic [1:0]        adr_t;   // word address on the bus

	////////////////////
	// multiply function, taken from cmd write bits 1:0
	////////////////////

	typedef enum logic [1:0] {
		mul_lo    = 2'd0, // MUL, low word
		mul_hi_ss = 2'd1, // MULH, signed x signed
		mul_hi_su = 2'd2, // MULHSU, signed x unsigned
		mul_hi_uu = 2'd3  // MULHU, unsigned x unsigned
	} mul_func_t;

	////////////////////
	// register map
	////////////////////

	localparam adr_t reg_opa    = 2'd0; // operand a, r/w
	localparam adr_t reg_opb    = 2'd1; // operand b, r/w

	// write launches a multiply
	// read gives status, fifo count in 7:0 and in-flight count in 15:8
	localparam adr_t reg_cmd    = 2'd2;

	// read pops the fifo, zero when empty; writes dropped
	localparam adr_t reg_result = 2'd3;

	// status field positions
	localparam int status_fifo_lsb   = 0;
	localparam int status_flight_lsb = 8;

endpackage

//--- mult_result_fifo.sv
`timescale 1ns/1ps

module mult_result_fifo #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic             clock,
	input  logic             reset,
	input  logic             push,
	input  mult_pkg::word_t  wdata,
	input  logic             pop,
	output mult_pkg::word_t  head,
	output mult_pkg::count_t count
);

	localparam int ptr_w = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

	mult_pkg::word_t  mem [FIFO_DEPTH]; // storage, no reset
	logic [ptr_w-1:0] rd_ptr, wr_ptr;
	logic             empty, full;
	logic             do_push, do_pop;

	// pointer step with wrap for any depth
	function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] ptr);
		logic [ptr_w-1:0] nxt;
		if (ptr == ptr_w'(FIFO_DEPTH - 1)) begin
			nxt = '0;
		end else begin
			nxt = ptr + 1'b1;
		end
		return nxt;
	endfunction

	assign empty = (count == '0);
	assign full  = (count == mult_pkg::count_t'(FIFO_DEPTH));

	assign do_pop  = pop && !empty;           // pop on empty dropped
	assign do_push = push && (!full || do_pop); // credits keep this from overflowing

	// zero when nothing stored
	assign head = empty ? '0 : mem[rd_ptr];

	////////////////////
	// storage write
	////////////////////

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= wdata;
		end
	end

	////////////////////
	// pointers and count
	////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			// push and pop together leave count alone
			count <= count + mult_pkg::count_t'(do_push) - mult_pkg::count_t'(do_pop);
		end
	end

endmodule

//--- mult_stage.sv
`timescale 1ns/1ps

module mult_stage #(
	parameter int NUM_STAGES = 4
) (
	input  logic             clock,
	input  logic             reset,
	input  logic             start,
	input  mult_pkg::dword_t mplier_in,
	input  mult_pkg::dword_t mcand_in,
	input  mult_pkg::dword_t product_in,
	input  logic             upper_in,
	output logic             done,
	output mult_pkg::dword_t mplier_out,
	output mult_pkg::dword_t mcand_out,
	output mult_pkg::dword_t product_out,
	output logic             upper_out
);

	// multiplier bits consumed per stage
	localparam int num_bits = $bits(mult_pkg::dword_t) / NUM_STAGES;

	mult_pkg::dword_t prod_in_reg;  // running sum from earlier stages
	mult_pkg::dword_t partial_prod; // this stage's slice product
	mult_pkg::dword_t next_partial;

	// slice x multiplicand, truncated to 64 bits
	assign next_partial = mplier_in[num_bits-1:0] * mcand_in;

	// sum leaves the stage combinationally from the two registers
	assign product_out = prod_in_reg + partial_prod;

	// datapath, no reset
	always_ff @(posedge clock) begin
		prod_in_reg  <= product_in;
		partial_prod <= next_partial;
		mplier_out   <= mplier_in >> num_bits; // drop used slice
		mcand_out    <= mcand_in << num_bits;  // weight for next slice
		upper_out    <= upper_in;              // travels with data
	end

	// valid flag
	always_ff @(posedge clock) begin
		if (reset) begin
			done <= 1'b0;
		end else begin
			done <= start;
		end
	end

endmodule

//--- mult_unit_top.sv
`timescale 1ns/1ps

module mult_unit_top #(
	parameter int NUM_STAGES = 4, // must divide 64
	parameter int FIFO_DEPTH = 8
) (
	input  logic            clock,
	input  logic            reset,
	input  logic            cyc,
	input  logic            stb,
	input  logic            we,
	input  mult_pkg::adr_t  adr,
	input  mult_pkg::word_t dat_w,
	output mult_pkg::word_t dat_r,
	output logic            ack
);

	logic                opa_load, opb_load; // operand strobes
	logic                start, pop;
	logic                done;
	mult_pkg::mul_func_t func;
	mult_pkg::word_t     opa, opb;
	mult_pkg::word_t     result;     // half-selected product
	mult_pkg::word_t     fifo_head;
	mult_pkg::count_t    fifo_count;

	////////////////////
	// bus side
	////////////////////

	mult_bus_ctrl #(.FIFO_DEPTH(FIFO_DEPTH)) i_bus_ctrl (
		.clock      (clock),
		.reset      (reset),
		.cyc        (cyc),
		.stb        (stb),
		.we         (we),
		.adr        (adr),
		.dat_w      (dat_w),
		.ack        (ack),
		.dat_r      (dat_r),
		.opa        (opa),
		.opb        (opb),
		.fifo_head  (fifo_head),
		.fifo_count (fifo_count),
		.done       (done),
		.opa_load   (opa_load),
		.opb_load   (opb_load),
		.start      (start),
		.func       (func),
		.pop        (pop)
	);

	mult_operand_regs i_operand_regs (
		.clock    (clock),
		.reset    (reset),
		.opa_load (opa_load),
		.opb_load (opb_load),
		.wdata    (dat_w),  // full-word writes only
		.opa      (opa),
		.opb      (opb)
	);

	////////////////////
	// datapath
	////////////////////

	mult_pipe #(.NUM_STAGES(NUM_STAGES)) i_pipe (
		.clock  (clock),
		.reset  (reset),
		.start  (start),
		.func   (func),
		.opa    (opa),
		.opb    (opb),
		.done   (done),
		.result (result)
	);

	mult_result_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_result_fifo (
		.clock (clock),
		.reset (reset),
		.push  (done),      // every finished multiply lands here
		.wdata (result),
		.pop   (pop),
		.head  (fifo_head),
		.count (fifo_count)
	);

endmodule

//--- tb_mult_checker.sv
`timescale 1ns/1ps

module tb_mult_checker (
	input  logic            clock,
	input  logic            reset,
	input  logic            cyc,
	input  logic            stb,
	input  logic            we,
	input  mult_pkg::adr_t  adr,
	input  mult_pkg::word_t dat_w,
	input  mult_pkg::word_t dat_r,
	input  logic            ack,
	input  logic            expected_valid, // one pulse per launch from the table
	input  mult_pkg::word_t expected_data,
	output int              error_count,
	output int              pending         // launched, not yet read
);

	mult_pkg::word_t exp_q [$];   // table values, launch order
	mult_pkg::word_t model_q [$]; // own model, launch order
	mult_pkg::word_t model_opa, model_opb;
	mult_pkg::word_t exp_val, model_val;
	logic            bus_ack;
	int              occupied;

	// 33-bit signed operands, the top bit picks signed or unsigned
	function automatic mult_pkg::word_t model_mul(input mult_pkg::word_t a,
			input mult_pkg::word_t b, input logic [1:0] f);
		logic signed [32:0] sa, sb;
		logic signed [65:0] p;
		sa = {(f != mult_pkg::mul_hi_uu) && a[31], a};
		sb = {((f == mult_pkg::mul_lo) || (f == mult_pkg::mul_hi_ss)) && b[31], b};
		p  = sa * sb;
		return (f == mult_pkg::mul_lo) ? p[31:0] : p[63:32];
	endfunction

	task automatic compare(input string name, input mult_pkg::word_t expected,
			input mult_pkg::word_t actual);
		if (actual !== expected) begin
			error_count++;
			$display("error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	assign bus_ack = ack && cyc && stb; // transfer completes at the next edge

	always @(posedge clock) begin
		if (reset) begin
			exp_q.delete();
			model_q.delete();
			model_opa   = '0;
			model_opb   = '0;
			error_count = 0;
		end else begin
			if (expected_valid) exp_q.push_back(expected_data);
			if (bus_ack && we) begin
				case (adr)
					mult_pkg::reg_opa: model_opa = dat_w;
					mult_pkg::reg_opb: model_opb = dat_w;
					mult_pkg::reg_cmd: model_q.push_back(model_mul(model_opa, model_opb, dat_w[1:0]));
					default: ; // result writes dropped
				endcase
			end
			if (bus_ack && !we) begin
				case (adr)
					mult_pkg::reg_opa: compare("dat_r (opa readback)", model_opa, dat_r);
					mult_pkg::reg_opb: compare("dat_r (opb readback)", model_opb, dat_r);
					mult_pkg::reg_cmd: begin
						// fifo + in-flight always adds up to launched minus read
						occupied = dat_r[7:0] + dat_r[15:8];
						compare("dat_r (status count sum)", model_q.size(), occupied);
						compare("dat_r (status upper bits)", '0, {16'h0, dat_r[31:16]});
					end
					default: begin
						if (model_q.size() == 0) begin
							if (exp_q.size() != 0) begin
								error_count++;
								$display("table expectation at %0t ns with no launched command", $time);
							end
							compare("dat_r (empty result read)", '0, dat_r);
						end else if (exp_q.size() == 0) begin
							error_count++;
							$display("command launched at %0t ns without a table expectation", $time);
							void'(model_q.pop_front());
						end else begin
							exp_val   = exp_q.pop_front();
							model_val = model_q.pop_front();
							if (exp_val !== model_val) begin
								error_count++;
								$display("table value %h and reference model %h disagree at %0t ns",
									exp_val, model_val, $time);
							end
							compare("dat_r (result)", model_val, dat_r);
						end
					end
				endcase
			end
			pending = model_q.size();
		end
	end

endmodule

//--- tb_mult_unit.sv
`timescale 1ns/1ps

module tb_mult_unit;

	localparam int num_stages      = 4;
	localparam int fifo_depth      = 8;
	localparam int num_directed    = 15;
	localparam int num_rows        = num_directed + 16; // plus random rows
	localparam int watchdog_cycles = num_rows * (num_stages + 20) + 200;

	logic            clock, reset, cyc, stb, we, ack;
	mult_pkg::adr_t  adr;
	mult_pkg::word_t dat_w, dat_r;
	logic            expected_valid;
	mult_pkg::word_t expected_data;
	int              checker_errors, checker_pending, tb_errors;
	int              seed, i, launched;
	mult_pkg::word_t rdata, ra, rb;
	logic [1:0]      rf;

	////////////////////
	// stimulus table
	////////////////////

	mult_pkg::word_t tab_a   [num_rows];
	mult_pkg::word_t tab_b   [num_rows];
	logic [1:0]      tab_f   [num_rows];
	mult_pkg::word_t tab_exp [num_rows];

	mult_unit_top #(.NUM_STAGES(num_stages), .FIFO_DEPTH(fifo_depth)) i_dut (
		.clock (clock),
		.reset (reset),
		.cyc   (cyc),
		.stb   (stb),
		.we    (we),
		.adr   (adr),
		.dat_w (dat_w),
		.dat_r (dat_r),
		.ack   (ack)
	);

	tb_mult_checker i_checker (
		.clock          (clock),
		.reset          (reset),
		.cyc            (cyc),
		.stb            (stb),
		.we             (we),
		.adr            (adr),
		.dat_w          (dat_w),
		.dat_r          (dat_r),
		.ack            (ack),
		.expected_valid (expected_valid),
		.expected_data  (expected_data),
		.error_count    (checker_errors),
		.pending        (checker_pending)
	);

	initial clock = 1'b0;
	always #4 clock = ~clock; // 8 ns period

	// unsigned product, high word corrected for each signed operand
	function automatic mult_pkg::word_t golden_mul(input mult_pkg::word_t a,
			input mult_pkg::word_t b, input logic [1:0] f);
		logic [63:0]     p;
		mult_pkg::word_t hi;
		p  = {32'h0, a} * {32'h0, b};
		hi = p[63:32];
		case (f)
			2'd0:    return p[31:0];
			2'd1:    return hi - (a[31] ? b : '0) - (b[31] ? a : '0);
			2'd2:    return hi - (a[31] ? b : '0);
			default: return hi;
		endcase
	endfunction

	task automatic set_row(input int n, input mult_pkg::word_t a, input mult_pkg::word_t b,
			input logic [1:0] f, input mult_pkg::word_t e);
		tab_a[n]   = a;
		tab_b[n]   = b;
		tab_f[n]   = f;
		tab_exp[n] = e;
	endtask

	// one classic cycle, entered and left 1 ns after an edge
	task automatic bus_cycle(input logic wr, input mult_pkg::adr_t a, input mult_pkg::word_t wd,
			input logic exp_v, input mult_pkg::word_t exp_d, output mult_pkg::word_t rd);
		cyc            = 1'b1;
		stb            = 1'b1;
		we             = wr;
		adr            = a;
		dat_w          = wd;
		expected_valid = exp_v; // single-cycle pulse
		expected_data  = exp_d;
		@(posedge clock); #1;
		expected_valid = 1'b0;
		while (!ack) begin
			@(posedge clock); #1; // wait states
		end
		rd = dat_r; // ack cycle
		@(posedge clock); #1;
		cyc = 1'b0;
		stb = 1'b0;
		we  = 1'b0;
		@(posedge clock); #1;
	endtask

	task automatic write_reg(input mult_pkg::adr_t a, input mult_pkg::word_t d);
		mult_pkg::word_t unused;
		bus_cycle(1'b1, a, d, 1'b0, '0, unused);
	endtask

	task automatic read_reg(input mult_pkg::adr_t a, output mult_pkg::word_t d);
		bus_cycle(1'b0, a, '0, 1'b0, '0, d);
	endtask

	task automatic launch(input logic [1:0] f, input mult_pkg::word_t e);
		mult_pkg::word_t unused;
		bus_cycle(1'b1, mult_pkg::reg_cmd, {30'h0, f}, 1'b1, e, unused);
	endtask

	// poll status until something is in the fifo, then pop it
	task automatic read_result();
		mult_pkg::word_t st, r;
		st = '0;
		while (st[7:0] == 8'h0) read_reg(mult_pkg::reg_cmd, st);
		read_reg(mult_pkg::reg_result, r);
	endtask

	// hold a command write with no credit, then abort it
	task automatic check_blocked_cmd(input logic [1:0] f);
		cyc   = 1'b1;
		stb   = 1'b1;
		we    = 1'b1;
		adr   = mult_pkg::reg_cmd;
		dat_w = {30'h0, f};
		repeat (num_stages + 4) begin
			@(posedge clock); #1;
			if (ack) begin
				tb_errors++;
				$display("command write acknowledged at %0t ns with no credit left", $time);
			end
		end
		cyc = 1'b0;
		stb = 1'b0;
		we  = 1'b0;
		@(posedge clock); #1;
	endtask

	////////////////////
	// watchdog
	////////////////////

	initial begin
		repeat (watchdog_cycles) @(posedge clock);
		$display("watchdog expired after %0d cycles, the DUT stopped answering", watchdog_cycles);
		$display("Verification failed");
		$finish;
	end

	initial begin
		seed           = 32'he402_8c1c;
		tb_errors      = 0;
		reset          = 1'b1;
		cyc            = 1'b0;
		stb            = 1'b0;
		we             = 1'b0;
		adr            = '0;
		dat_w          = '0;
		expected_valid = 1'b0;
		expected_data  = '0;

		// directed corners, f: 0 mul, 1 mulh, 2 mulhsu, 3 mulhu
		set_row(0, 32'h0000_0000, 32'h1234_5678, 2'd0, 32'h0000_0000);
		set_row(1, 32'h0000_0001, 32'hdead_beef, 2'd0, 32'hdead_beef);
		set_row(2, 32'hdead_beef, 32'h0000_0001, 2'd1, 32'hffff_ffff);
		set_row(3, 32'hffff_ffff, 32'hffff_ffff, 2'd0, 32'h0000_0001);
		set_row(4, 32'hffff_ffff, 32'hffff_ffff, 2'd1, 32'h0000_0000);
		set_row(5, 32'hffff_ffff, 32'hffff_ffff, 2'd2, 32'hffff_ffff);
		set_row(6, 32'hffff_ffff, 32'hffff_ffff, 2'd3, 32'hffff_fffe);
		set_row(7, 32'h8000_0000, 32'h8000_0000, 2'd1, 32'h4000_0000);
		set_row(8, 32'h8000_0000, 32'h8000_0000, 2'd2, 32'hc000_0000);
		set_row(9, 32'h8000_0000, 32'hffff_ffff, 2'd0, 32'h8000_0000);
		set_row(10, 32'h8000_0000, 32'hffff_ffff, 2'd1, 32'h0000_0000);
		set_row(11, 32'h8000_0000, 32'hffff_ffff, 2'd3, 32'h7fff_ffff);
		set_row(12, 32'hffff_fffe, 32'h0000_0003, 2'd2, 32'hffff_ffff); // -2 x 3
		set_row(13, 32'h0000_0003, 32'hffff_fffe, 2'd2, 32'h0000_0002); // b unsigned here
		set_row(14, 32'h0000_0007, 32'hffff_fffb, 2'd0, 32'hffff_ffdd); // 7 x -5
		for (i = num_directed; i < num_rows; i++) begin
			ra = $random(seed);
			rb = $random(seed);
			rf = $random(seed);
			set_row(i, ra, rb, rf, golden_mul(ra, rb, rf));
		end

		repeat (2) @(posedge clock);
		#1 reset = 1'b0;
		@(posedge clock); #1;

		// after reset, everything reads zero
		read_reg(mult_pkg::reg_opa, rdata);
		read_reg(mult_pkg::reg_opb, rdata);
		read_reg(mult_pkg::reg_cmd, rdata);
		read_reg(mult_pkg::reg_result, rdata); // empty pop
		read_reg(mult_pkg::reg_cmd, rdata);

		////////////////////
		// table, back-to-back batches
		////////////////////

		launched = 0;
		for (i = 0; i < num_rows; i++) begin
			write_reg(mult_pkg::reg_opa, tab_a[i]);
			write_reg(mult_pkg::reg_opb, tab_b[i]);
			if (i % 4 == 0) begin
				read_reg(mult_pkg::reg_opa, rdata); // readback now and then
				read_reg(mult_pkg::reg_opb, rdata);
			end
			launch(tab_f[i], tab_exp[i]);
			read_reg(mult_pkg::reg_cmd, rdata); // counts rising
			launched++;
			if (launched == fifo_depth || i == num_rows - 1) begin
				repeat (launched) read_result(); // launch order
				launched = 0;
			end
		end

		////////////////////
		// back-pressure
		////////////////////

		ra = 32'h8765_4321;
		rb = 32'hc0de_0007;
		write_reg(mult_pkg::reg_opa, ra);
		write_reg(mult_pkg::reg_opb, rb);
		for (i = 0; i < fifo_depth; i++) begin
			launch(i[1:0], golden_mul(ra, rb, i[1:0])); // same operands, all functions
		end
		check_blocked_cmd(2'd1);
		read_result(); // frees one credit
		launch(2'd1, golden_mul(ra, rb, 2'd1));
		repeat (fifo_depth) read_result();
		read_reg(mult_pkg::reg_result, rdata); // empty again
		read_reg(mult_pkg::reg_cmd, rdata);

		if (checker_pending != 0) begin
			tb_errors++;
			$display("%0d launched results were never read back", checker_pending);
		end
		$display("errors: checker %0d, testbench %0d", checker_errors, tb_errors);
		if (checker_errors == 0 && tb_errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

//--- verilog.f
mult_pkg.sv
mult_stage.sv
mult_pipe.sv
mult_operand_regs.sv
mult_result_fifo.sv
mult_bus_ctrl.sv
mult_unit_top.sv
tb_mult_checker.sv
tb_mult_unit.sv
